// ==== verification/radio_input.txt ====
# Command letter then hex fields. W mod ioc data, R mod ioc expect, O {led0,led1,mixer}
# P mode {rx_h_tx_l,rx_h_tx_l_b,tr_vc1,tr_vc1_b,tr_vc2,shdn_rx,shdn_tx}, S lane word, G idle
# D word, E no read request, V lane count of random words, Q count of queued words read back
R 0 01 02
W 0 02 5c
R 0 02 5c
R 3 07 a5
R 0 1f 00
R 1 03 19
W 1 02 01
O 1
P 1 4b
P 2 51
P 3 4d
P 4 32
P 5 2e
P 0 2b
W 2 03 01
O 5
S 09 8123f00d
G 7
S 09 9abcdef0
S 09 a5a50f0f
R 2 04 00
D 8123f00d
D 9abcdef0
D a5a50f0f
E
R 2 04 01
W 2 02 01
O 7
S 09 b00dcafe
G 4
S 24 86427531
D 86427531
E
V 24 0a
Q 08
E
R 2 04 01

// ==== all.f ====
+incdir+common
common/radio_pkg.sv
common/reg_bus_if.sv
hw/spi_slave.sv
hw/ctrl_regs.sv
rx/lvds_rx_deser.sv
rx/sample_fifo.sv
hw/smi_reader.sv
hw/radio_top.sv
verification/radio_assertions.sv
verification/radio_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= radio_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/radio_tb.sv ====
`include "radio_params.svh"

module radio_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int SPI_HALF     = 6;     // Clocks per SCK half period
  localparam int SOE_HALF     = 4;     // SMI strobe high and low time
  localparam int WAIT_LIMIT   = 2000;  // Cycles before a wait gives up

  logic       glob_clock;
  logic       rst_b;
  logic       sck;
  logic       mosi;
  logic       ss;
  wire        miso;                    // Tristate while deselected
  logic [1:0] pair_09;
  logic [1:0] pair_24;
  logic       smi_soe_se;
  logic [`RADIO_BYTE_W-1:0] smi_data;
  logic       smi_data_oe;
  logic       smi_read_req;
  logic       board_button;
  logic [3:0] board_config;
  logic       led0;
  logic       led1;
  logic       mixer_en;
  logic       rx_h_tx_l;
  logic       rx_h_tx_l_b;
  logic       tr_vc1;
  logic       tr_vc1_b;
  logic       tr_vc2;
  logic       shdn_rx_lna;
  logic       shdn_tx_lna;
  logic [6:0] rf_outs;                 // Same order as the P lines of the data file

  integer      seed = 32'h2c07;
  logic [31:0] sent_q [$];             // Words streamed by V in send order

  assign rf_outs = {rx_h_tx_l, rx_h_tx_l_b, tr_vc1, tr_vc1_b, tr_vc2, shdn_rx_lna, shdn_tx_lna};

  radio_top radio_top_inst (
    .i_glob_clock    (glob_clock),
    .i_rst_b         (rst_b),
    .i_sck           (sck),
    .i_mosi          (mosi),
    .i_ss            (ss),
    .o_miso          (miso),
    .i_iq_rx_09_pair (pair_09),
    .i_iq_rx_24_pair (pair_24),
    .i_smi_soe_se    (smi_soe_se),
    .o_smi_data      (smi_data),
    .o_smi_data_oe   (smi_data_oe),
    .o_smi_read_req  (smi_read_req),
    .i_button        (board_button),
    .i_config        (board_config),
    .o_led0          (led0),
    .o_led1          (led1),
    .o_mixer_en      (mixer_en),
    .o_rx_h_tx_l     (rx_h_tx_l),
    .o_rx_h_tx_l_b   (rx_h_tx_l_b),
    .o_tr_vc1        (tr_vc1),
    .o_tr_vc1_b      (tr_vc1_b),
    .o_tr_vc2        (tr_vc2),
    .o_shdn_rx_lna   (shdn_rx_lna),
    .o_shdn_tx_lna   (shdn_tx_lna)
  );

  bind radio_top radio_assertions radio_assertions_inst (
    .i_glob_clock   (i_glob_clock),
    .i_rst_b        (i_rst_b),
    .i_smi_data_oe  (o_smi_data_oe),
    .i_led0         (o_led0),
    .i_rx_h_tx_l    (o_rx_h_tx_l),
    .i_rx_h_tx_l_b  (o_rx_h_tx_l_b),
    .i_shdn_rx_lna  (o_shdn_rx_lna),
    .i_shdn_tx_lna  (o_shdn_tx_lna),
    .i_smi_read_req (o_smi_read_req)
  );

  initial begin
    glob_clock = 1'b0;
    forever #(CLK_PERIOD / 2) glob_clock = ~glob_clock;
  end

  // ========================================
  // Checks
  // ========================================
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "Stopped at the first error");
    end
  endtask

  task automatic fail_with(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("*** FAILED ***");
    $fatal(1, "Stopped at the first error");
  endtask

  // ========================================
  // SPI master, mode 0, MSB first
  // ========================================
  task automatic spi_frame(input logic [15:0] frame, output logic [7:0] rx);
    int i;
    rx = '0;
    @(posedge glob_clock);
    ss <= 1'b0;
    repeat (SPI_HALF) @(posedge glob_clock);
    for (i = 15; i >= 0; i--) begin
      mosi <= frame[i];               // Data moves while SCK is low
      repeat (SPI_HALF - 1) @(posedge glob_clock);
      @(negedge glob_clock);
      if (i < 8) rx[i] = miso;        // Sampled just before the rising SCK
      @(posedge glob_clock);
      sck <= 1'b1;
      repeat (SPI_HALF) @(posedge glob_clock);
      sck <= 1'b0;
    end
    repeat (SPI_HALF) @(posedge glob_clock);
    ss <= 1'b1;
    repeat (SPI_HALF) @(posedge glob_clock);  // Load lands well inside this gap
  endtask

  task automatic spi_write(input logic [1:0] mod_sel, input logic [4:0] ioc,
                           input logic [7:0] data);
    logic [7:0] unused_rx;
    spi_frame({1'b1, mod_sel, ioc, data}, unused_rx);
  endtask

  task automatic spi_read(input logic [1:0] mod_sel, input logic [4:0] ioc,
                          input logic [7:0] expected);
    logic [7:0] rx;
    spi_frame({1'b0, mod_sel, ioc, 8'h00}, rx);
    check_value($sformatf("o_miso byte of module %0d ioc %0d", mod_sel, ioc), rx, expected);
  endtask

  // ========================================
  // LVDS lanes and SMI host
  // ========================================
  task automatic send_word(input logic is_24, input logic [31:0] word);
    int i;
    for (i = `RADIO_PAIRS_PER_WORD - 1; i >= 0; i--) begin
      @(posedge glob_clock);
      if (is_24) pair_24 <= ~word[2*i +: 2];  // Board inverts this lane
      else pair_09 <= word[2*i +: 2];
    end
    @(posedge glob_clock);
    pair_09 <= 2'b00;                 // Idle pairs never match sync
    pair_24 <= 2'b11;
  endtask

  task automatic smi_read_word(input logic [31:0] expected);
    int n;
    int b;
    n = 0;
    @(negedge glob_clock);
    while (smi_read_req !== 1'b1) begin
      if (n == WAIT_LIMIT) fail_with("o_smi_read_req did not rise for a pending word");
      else begin
        n++;
        @(negedge glob_clock);
      end
    end
    for (b = 3; b >= 0; b--) begin    // MSB byte first
      check_value("o_smi_data", smi_data, expected[8*b +: 8]);
      @(posedge glob_clock);
      smi_soe_se <= 1'b1;
      repeat (SOE_HALF) @(posedge glob_clock);
      smi_soe_se <= 1'b0;
      repeat (SOE_HALF) @(posedge glob_clock);
      @(negedge glob_clock);
    end
  endtask

  task automatic stream_random(input logic is_24, input int count);
    int k;
    logic [31:0] w;
    sent_q.delete();
    for (k = 0; k < count; k++) begin
      w = $random(seed);
      w[31:30] = `RADIO_SYNC_PAIR;    // Every word opens with sync
      sent_q.push_back(w);
      send_word(is_24, w);
    end
  endtask

  task automatic read_queued(input int count);
    int k;
    logic [31:0] w;
    for (k = 0; k < count; k++) begin
      if (sent_q.size() == 0) fail_with("more SMI reads requested than words streamed");
      else begin
        w = sent_q.pop_front();
        smi_read_word(w);
      end
    end
    sent_q.delete();                  // Words past the FIFO depth were dropped
  endtask

  // ========================================
  // Main sequence from the data file
  // ========================================
  initial begin
    string       line;
    integer      fd;
    byte         cmd;
    logic [31:0] a1;
    logic [31:0] a2;
    logic [31:0] a3;
    rst_b        = 1'b0;
    sck          = 1'b0;
    mosi         = 1'b0;
    ss           = 1'b1;
    pair_09      = 2'b00;
    pair_24      = 2'b11;
    smi_soe_se   = 1'b0;
    board_button = 1'b1;
    board_config = 4'h9;              // io ioc 3 then reads 0x19
    repeat (RESET_CYCLES) @(posedge glob_clock);
    rst_b <= 1'b1;
    @(negedge glob_clock);
    check_value("{o_smi_read_req,o_smi_data_oe,o_led0,o_led1,o_mixer_en}",
                {smi_read_req, smi_data_oe, led0, led1, mixer_en}, 5'b00000);
    check_value("rf front-end outputs", rf_outs, 7'b0101011);  // Low power with both LNAs off

    fd = $fopen("verification/radio_input.txt", "r");
    if (fd == 0) fail_with("cannot open verification/radio_input.txt");
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      cmd = line.getc(0);
      a1 = '0;
      a2 = '0;
      a3 = '0;
      void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a1, a2, a3));
      case (cmd)
        "W": spi_write(a1[1:0], a2[4:0], a3[7:0]);
        "R": spi_read(a1[1:0], a2[4:0], a3[7:0]);
        "P": begin
          spi_write(2'd1, 5'd1, a1[7:0]);  // io ioc 1 holds the RF mode
          @(negedge glob_clock);
          check_value($sformatf("rf front-end outputs in mode %0d", a1), rf_outs, a2);
        end
        "O": begin
          @(negedge glob_clock);
          check_value("{o_led0,o_led1,o_mixer_en}", {led0, led1, mixer_en}, a1);
        end
        "S": send_word(a1 == 32'h24, a2);
        "G": repeat (a1) @(posedge glob_clock);
        "D": smi_read_word(a1);
        "E": begin
          @(negedge glob_clock);
          check_value("o_smi_read_req", smi_read_req, 1'b0);
        end
        "V": stream_random(a1 == 32'h24, a2);
        "Q": read_queued(a1);
        default: fail_with($sformatf("unknown command in data file: %s", line));
      endcase
    end
    $fclose(fd);

    repeat (4) @(posedge glob_clock);
    if (radio_top_inst.radio_assertions_inst.fail_count == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("Error: %0d assertion failures", radio_top_inst.radio_assertions_inst.fail_count);
      $display("*** FAILED ***");
      $fatal(1, "Assertion failures during the run");
    end
  end

endmodule

// ==== verification/radio_assertions.sv ====
// Structural checks on the radio top level, attached by bind
module radio_assertions (
  input logic i_glob_clock,
  input logic i_rst_b,
  input logic i_smi_data_oe,
  input logic i_led0,
  input logic i_rx_h_tx_l,
  input logic i_rx_h_tx_l_b,
  input logic i_shdn_rx_lna,
  input logic i_shdn_tx_lna,
  input logic i_smi_read_req
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_oe   = 0;  // One counter per property
  int fail_inv  = 0;
  int fail_lna  = 0;
  int fail_req  = 0;
  int fail_count;     // Read by the testbench at the end

  assign fail_count = fail_oe + fail_inv + fail_lna + fail_req;

  // SMI drive enable and LED0 both come from the direction bit
  a_oe_led: assert property (@(posedge i_glob_clock) disable iff (!i_rst_b)
      i_smi_data_oe == i_led0)
    else begin
      fail_oe++;
      $error("SMI output enable differs from LED0");
    end

  a_rx_inv: assert property (@(posedge i_glob_clock) disable iff (!i_rst_b)
      i_rx_h_tx_l_b == !i_rx_h_tx_l)  // Complementary switch drive
    else begin
      fail_inv++;
      $error("rx_h_tx_l pair is not complementary");
    end

  // Never both LNAs powered at once
  a_lna_excl: assert property (@(posedge i_glob_clock) disable iff (!i_rst_b)
      i_shdn_rx_lna || i_shdn_tx_lna)
    else begin
      fail_lna++;
      $error("RX and TX LNA both enabled");
    end

  a_req_oe: assert property (@(posedge i_glob_clock) disable iff (!i_rst_b)
      i_smi_read_req |-> i_smi_data_oe)
    else begin
      fail_req++;
      $error("SMI read request without output enable");
    end

endmodule

// ==== hw/radio_top.sv ====
`include "radio_params.svh"

module radio_top import radio_pkg::*; (
  input  logic                     i_glob_clock,
  input  logic                     i_rst_b,
  // SPI
  input  logic                     i_sck,
  input  logic                     i_mosi,
  input  logic                     i_ss,
  output logic                     o_miso,
  // Modem LVDS lanes
  input  logic [1:0]               i_iq_rx_09_pair,
  input  logic [1:0]               i_iq_rx_24_pair,   // Arrives inverted
  // SMI
  input  logic                     i_smi_soe_se,
  output logic [`RADIO_BYTE_W-1:0] o_smi_data,
  output logic                     o_smi_data_oe,
  output logic                     o_smi_read_req,
  // Board
  input  logic                     i_button,
  input  logic [3:0]               i_config,
  output logic                     o_led0,
  output logic                     o_led1,
  output logic                     o_mixer_en,
  // RF front end
  output logic                     o_rx_h_tx_l,
  output logic                     o_rx_h_tx_l_b,
  output logic                     o_tr_vc1,
  output logic                     o_tr_vc1_b,
  output logic                     o_tr_vc2,
  output logic                     o_shdn_rx_lna,
  output logic                     o_shdn_tx_lna
);

  reg_bus_if bus_if ();

  logic      w_miso;
  logic      w_channel;
  logic      w_smi_dir;
  ddr_pair_t w_pair_24;
  logic      w_push_09;
  logic      w_push_24;
  sample_t   w_word_09;
  sample_t   w_word_24;
  logic      w_fifo_push;
  sample_t   w_fifo_word;
  logic      w_fifo_pop;
  sample_t   w_fifo_head;
  logic      w_fifo_empty;

  // ========================================
  // Control path
  // ========================================
  spi_slave spi_slave_inst (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .i_sck        (i_sck),
    .i_mosi       (i_mosi),
    .i_ss         (i_ss),
    .o_miso       (w_miso),
    .bus          (bus_if.master)
  );

  assign o_miso = i_ss ? 1'bz : w_miso;  // Bus released while deselected

  ctrl_regs ctrl_regs_inst (
    .i_glob_clock  (i_glob_clock),
    .i_rst_b       (i_rst_b),
    .bus           (bus_if.slave),
    .i_button      (i_button),
    .i_config      (i_config),
    .i_fifo_empty  (w_fifo_empty),
    .o_channel     (w_channel),
    .o_smi_dir     (w_smi_dir),
    .o_mixer_en    (o_mixer_en),
    .o_rx_h_tx_l   (o_rx_h_tx_l),
    .o_rx_h_tx_l_b (o_rx_h_tx_l_b),
    .o_tr_vc1      (o_tr_vc1),
    .o_tr_vc1_b    (o_tr_vc1_b),
    .o_tr_vc2      (o_tr_vc2),
    .o_shdn_rx_lna (o_shdn_rx_lna),
    .o_shdn_tx_lna (o_shdn_tx_lna)
  );

  assign o_led0 = w_smi_dir;
  assign o_led1 = w_channel;

  // ========================================
  // Receive path
  // ========================================
  assign w_pair_24 = ~i_iq_rx_24_pair;  // Undo the board-level inversion

  lvds_rx_deser lvds_rx_09_inst (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .i_pair       (i_iq_rx_09_pair),
    .o_push       (w_push_09),
    .o_word       (w_word_09)
  );

  lvds_rx_deser lvds_rx_24_inst (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .i_pair       (w_pair_24),
    .o_push       (w_push_24),
    .o_word       (w_word_24)
  );

  // Only the selected lane reaches the FIFO
  assign w_fifo_push = w_channel ? w_push_24 : w_push_09;
  assign w_fifo_word = w_channel ? w_word_24 : w_word_09;

  sample_fifo sample_fifo_inst (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .i_push       (w_fifo_push),
    .i_word       (w_fifo_word),
    .i_pop        (w_fifo_pop),
    .o_head       (w_fifo_head),
    .o_empty      (w_fifo_empty)
  );

  smi_reader smi_reader_inst (
    .i_glob_clock   (i_glob_clock),
    .i_rst_b        (i_rst_b),
    .i_smi_soe_se   (i_smi_soe_se),
    .i_dir          (w_smi_dir),
    .i_head         (w_fifo_head),
    .i_empty        (w_fifo_empty),
    .o_pop          (w_fifo_pop),
    .o_smi_data     (o_smi_data),
    .o_smi_data_oe  (o_smi_data_oe),
    .o_smi_read_req (o_smi_read_req)
  );

endmodule

// ==== hw/smi_reader.sv ====
`include "radio_params.svh"

module smi_reader import radio_pkg::*; (
  input  logic                     i_glob_clock,
  input  logic                     i_rst_b,
  input  logic                     i_smi_soe_se,   // Host read strobe
  input  logic                     i_dir,
  input  sample_t                  i_head,
  input  logic                     i_empty,
  output logic                     o_pop,
  output logic [`RADIO_BYTE_W-1:0] o_smi_data,
  output logic                     o_smi_data_oe,
  output logic                     o_smi_read_req
);

  logic [2:0] r_soe_sync;   // Two sync flops plus edge history
  logic [1:0] r_byte_idx;   // Byte of the head word on the bus
  logic       w_strobe;

  assign w_strobe = r_soe_sync[1] && !r_soe_sync[2];  // Rising strobe

  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      r_soe_sync <= '0;
      r_byte_idx <= 2'd3;  // MSB byte first
    end else begin
      r_soe_sync <= {r_soe_sync[1:0], i_smi_soe_se};
      if (w_strobe && o_smi_read_req) begin
        r_byte_idx <= r_byte_idx - 2'd1;  // 0 wraps back to 3
      end
    end
  end

  // Last byte taken so release the word
  assign o_pop          = w_strobe && o_smi_read_req && (r_byte_idx == 2'd0);
  assign o_smi_data     = i_head[{r_byte_idx, 3'b000} +: `RADIO_BYTE_W];
  assign o_smi_data_oe  = i_dir;
  assign o_smi_read_req = i_dir && !i_empty;

endmodule

// ==== rx/sample_fifo.sv ====
`include "radio_params.svh"

module sample_fifo import radio_pkg::*; (
  input  logic    i_glob_clock,
  input  logic    i_rst_b,
  input  logic    i_push,
  input  sample_t i_word,
  input  logic    i_pop,
  output sample_t o_head,   // Show-ahead, valid while not empty
  output logic    o_empty
);

  localparam int PTR_W = $clog2(`RADIO_FIFO_DEPTH);

  sample_t          r_mem [`RADIO_FIFO_DEPTH];
  logic [PTR_W-1:0] r_wr_ptr;   // Wraps on its own since depth is 2^n
  logic [PTR_W-1:0] r_rd_ptr;
  logic [PTR_W:0]   r_count;
  logic             w_full;
  logic             w_do_push;
  logic             w_do_pop;

  assign w_full    = (r_count == (PTR_W + 1)'(`RADIO_FIFO_DEPTH));
  assign o_empty   = (r_count == '0);
  assign w_do_push = i_push && !w_full;   // Word is lost when full
  assign w_do_pop  = i_pop && !o_empty;
  assign o_head    = r_mem[r_rd_ptr];

  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (w_do_push) r_wr_ptr <= r_wr_ptr + 1'b1;
      if (w_do_pop)  r_rd_ptr <= r_rd_ptr + 1'b1;
      case ({w_do_push, w_do_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: ;  // Both or neither keeps the level
      endcase
    end
  end

  // Storage
  always_ff @(posedge i_glob_clock) begin
    if (w_do_push) r_mem[r_wr_ptr] <= i_word;
  end

endmodule

// ==== rx/lvds_rx_deser.sv ====
`include "radio_params.svh"

module lvds_rx_deser import radio_pkg::*; (
  input  logic      i_glob_clock,
  input  logic      i_rst_b,
  input  ddr_pair_t i_pair,   // One DDR pair per clock
  output logic      o_push,   // Word complete
  output sample_t   o_word
);

  localparam int CNT_W = $clog2(`RADIO_PAIRS_PER_WORD);

  typedef enum logic {
    ST_IDLE,     // Hunting for the sync pair
    ST_COLLECT   // Taking the remaining pairs
  } state_t;

  state_t           r_state;
  logic [CNT_W-1:0] r_pair_cnt;  // Pairs already in the word

  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      r_state    <= ST_IDLE;
      r_pair_cnt <= '0;
      o_push     <= 1'b0;
    end else begin
      o_push <= 1'b0;
      case (r_state)
        ST_IDLE: begin
          if (i_pair == `RADIO_SYNC_PAIR) begin
            r_state    <= ST_COLLECT;
            r_pair_cnt <= CNT_W'(1);  // Sync counts as pair 1
          end
        end
        ST_COLLECT: begin
          r_pair_cnt <= r_pair_cnt + 1'b1;
          if (r_pair_cnt == CNT_W'(`RADIO_PAIRS_PER_WORD - 1)) begin
            r_state <= ST_IDLE;  // Back-to-back words are fine
            o_push  <= 1'b1;
          end
        end
        default: r_state <= ST_IDLE;
      endcase
    end
  end

  // Free-running shifter, after 16 pairs the sync pair sits in bits 31:30
  always_ff @(posedge i_glob_clock) begin
    o_word <= {o_word[`RADIO_SAMPLE_W-3:0], i_pair};
  end

endmodule

// ==== hw/ctrl_regs.sv ====
`include "radio_params.svh"

module ctrl_regs import radio_pkg::*; (
  input  logic       i_glob_clock,
  input  logic       i_rst_b,
  reg_bus_if.slave   bus,
  input  logic       i_button,
  input  logic [3:0] i_config,
  input  logic       i_fifo_empty,
  output logic       o_channel,      // 0 = 0.9 GHz lane, 1 = 2.4 GHz lane
  output logic       o_smi_dir,      // 1 = FPGA drives the SMI bus
  output logic       o_mixer_en,
  output logic       o_rx_h_tx_l,
  output logic       o_rx_h_tx_l_b,
  output logic       o_tr_vc1,
  output logic       o_tr_vc1_b,
  output logic       o_tr_vc2,
  output logic       o_shdn_rx_lna,
  output logic       o_shdn_tx_lna
);

  logic [`RADIO_BYTE_W-1:0] r_scratch;
  rf_mode_t                 r_rf_mode;
  logic [`RADIO_BYTE_W-1:0] w_rdata;

  // ========================================
  // Register writes
  // ========================================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      r_scratch  <= '0;
      r_rf_mode  <= RF_LOWPWR;  // Front end powered down
      o_mixer_en <= 1'b0;
      o_channel  <= 1'b0;
      o_smi_dir  <= 1'b0;
    end else if (bus.load) begin
      case (bus.mod_sel)
        MOD_SYS: begin
          if (bus.ioc == 5'd2) r_scratch <= bus.wdata;
        end
        MOD_IO: begin
          case (bus.ioc)
            5'd1:    r_rf_mode  <= rf_mode_t'(bus.wdata[2:0]);
            5'd2:    o_mixer_en <= bus.wdata[0];
            default: ;
          endcase
        end
        MOD_SMI: begin
          case (bus.ioc)
            5'd2:    o_channel <= bus.wdata[0];
            5'd3:    o_smi_dir <= bus.wdata[0];
            default: ;
          endcase
        end
        default: ;  // Reserved module takes no writes
      endcase
    end
  end

  // ========================================
  // Read-back mux
  // ========================================
  always_comb begin
    w_rdata = '0;  // Unmapped registers read zero
    case (bus.mod_sel)
      MOD_SYS: begin
        case (bus.ioc)
          5'd1:    w_rdata = `RADIO_VERSION;
          5'd2:    w_rdata = r_scratch;
          default: ;
        endcase
      end
      MOD_IO: begin
        case (bus.ioc)
          5'd1:    w_rdata = {5'd0, r_rf_mode};
          5'd2:    w_rdata = {7'd0, o_mixer_en};
          5'd3:    w_rdata = {3'd0, i_button, i_config};  // Live board status
          default: ;
        endcase
      end
      MOD_SMI: begin
        case (bus.ioc)
          5'd2:    w_rdata = {7'd0, o_channel};
          5'd3:    w_rdata = {7'd0, o_smi_dir};
          5'd4:    w_rdata = {7'd0, i_fifo_empty};
          default: ;
        endcase
      end
      default: w_rdata = `RADIO_RESERVED_READ;
    endcase
  end

  // Captured on the edge after fetch, held for the MISO shifter
  always_ff @(posedge i_glob_clock) begin
    if (bus.fetch) bus.rdata <= w_rdata;
  end

  // ========================================
  // RF front-end decode
  // ========================================
  assign o_rx_h_tx_l   = r_rf_mode inside {RF_BYPASS, RF_RX_LP, RF_RX_HP};
  assign o_tr_vc1      = r_rf_mode inside {RF_RX_LP, RF_TX_LP};   // Low-pass leg
  assign o_tr_vc2      = r_rf_mode inside {RF_RX_HP, RF_TX_HP};   // High-pass leg
  assign o_shdn_rx_lna = !(r_rf_mode inside {RF_RX_LP, RF_RX_HP});
  assign o_shdn_tx_lna = !(r_rf_mode inside {RF_TX_LP, RF_TX_HP});
  assign o_rx_h_tx_l_b = !o_rx_h_tx_l;
  assign o_tr_vc1_b    = !o_tr_vc1;

endmodule

// ==== hw/spi_slave.sv ====
`include "radio_params.svh"

module spi_slave import radio_pkg::*; (
  input  logic      i_glob_clock,
  input  logic      i_rst_b,
  input  logic      i_sck,
  input  logic      i_mosi,
  input  logic      i_ss,
  output logic      o_miso,
  reg_bus_if.master bus
);

  // ========================================
  // Pin synchronizers and SCK edges
  // ========================================
  logic [2:0] r_sck_sync;   // Two sync flops plus edge history
  logic [1:0] r_mosi_sync;
  logic [1:0] r_ss_sync;
  logic       w_sck_rise;
  logic       w_sck_fall;
  logic       w_ss_active;

  assign w_sck_rise  = r_sck_sync[1] && !r_sck_sync[2];
  assign w_sck_fall  = !r_sck_sync[1] && r_sck_sync[2];
  assign w_ss_active = !r_ss_sync[1];  // Select is active low

  // ========================================
  // Frame state
  // ========================================
  logic [3:0]               r_bit_cnt;    // Position in the 16-bit frame
  logic [2:0]               r_byte_dly;   // Byte-complete delay line
  logic                     r_is_write;   // Bit 7 of the command, 1 = write
  logic [`RADIO_BYTE_W-1:0] r_shift_in;
  logic [`RADIO_BYTE_W-1:0] r_shift_out;
  logic                     w_byte_end;
  logic                     w_first_byte;

  assign w_byte_end   = w_sck_rise && (r_bit_cnt[2:0] == 3'd7);
  assign w_first_byte = r_bit_cnt[3];  // Counter sits at 8..15 after the command

  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      r_sck_sync  <= '0;
      r_mosi_sync <= '0;
      r_ss_sync   <= 2'b11;  // Deselected
      r_bit_cnt   <= '0;
      r_byte_dly  <= '0;
      r_is_write  <= 1'b0;
      r_shift_out <= '0;
    end else begin
      r_sck_sync  <= {r_sck_sync[1:0], i_sck};
      r_mosi_sync <= {r_mosi_sync[0], i_mosi};
      r_ss_sync   <= {r_ss_sync[0], i_ss};
      r_byte_dly  <= {r_byte_dly[1:0], w_byte_end};

      if (!w_ss_active) begin
        r_bit_cnt <= '0;  // Realign on every new frame
      end else if (w_sck_rise) begin
        r_bit_cnt <= r_bit_cnt + 4'd1;
      end

      if (r_byte_dly[0] && w_first_byte) begin
        r_is_write <= r_shift_in[7];
      end

      // MISO changes on falling SCK, the master samples on rising
      if (w_sck_fall) begin
        if (r_bit_cnt == 4'd8) begin
          r_shift_out <= bus.rdata;  // First fall of the data byte
        end else begin
          r_shift_out <= {r_shift_out[`RADIO_BYTE_W-2:0], 1'b0};
        end
      end
    end
  end

  // MOSI shifter and command fields
  always_ff @(posedge i_glob_clock) begin
    if (w_sck_rise) begin
      r_shift_in <= {r_shift_in[`RADIO_BYTE_W-2:0], r_mosi_sync[1]};  // MSB first
    end
    if (r_byte_dly[0] && w_first_byte) begin
      bus.mod_sel <= reg_module_t'(r_shift_in[6:5]);
      bus.ioc     <= r_shift_in[4:0];
    end
  end

  // Strobes land 3 cycles after the SCK rise that closes the byte
  assign bus.load  = r_byte_dly[2] && !w_first_byte && r_is_write;
  assign bus.fetch = r_byte_dly[2] && w_first_byte && !r_is_write;
  assign bus.wdata = r_shift_in;  // Data byte, stable until the next SCK rise
  assign o_miso    = r_shift_out[`RADIO_BYTE_W-1];

endmodule

// ==== common/reg_bus_if.sv ====
`include "radio_params.svh"

// Register access path from the SPI slave into the register block
interface reg_bus_if import radio_pkg::*; ();

  reg_module_t              mod_sel;  // Target module
  logic [`RADIO_IOC_W-1:0]  ioc;      // Register number
  logic [`RADIO_BYTE_W-1:0] wdata;    // Valid with load
  logic [`RADIO_BYTE_W-1:0] rdata;    // Registered one edge after fetch
  logic                     load;     // Single-cycle write strobe
  logic                     fetch;    // Single-cycle read request

  modport master (
    output mod_sel, ioc, wdata, load, fetch,
    input  rdata
  );

  modport slave (
    input  mod_sel, ioc, wdata, load, fetch,
    output rdata
  );

endinterface

// ==== common/radio_pkg.sv ====
`include "radio_params.svh"

package radio_pkg;

  // Module select, bits 6:5 of the SPI command byte
  typedef enum logic [1:0] {
    MOD_SYS  = 2'd0,  // Version and scratch
    MOD_IO   = 2'd1,  // RF mode, mixer, board status
    MOD_SMI  = 2'd2,  // Channel, direction, FIFO status
    MOD_RSVD = 2'd3   // Nothing behind it
  } reg_module_t;

  // RF front-end operating mode
  typedef enum logic [2:0] {
    RF_LOWPWR = 3'd0,  // Everything off
    RF_BYPASS = 3'd1,
    RF_RX_LP  = 3'd2,  // Receive through the low-pass leg
    RF_RX_HP  = 3'd3,  // Receive through the high-pass leg
    RF_TX_LP  = 3'd4,
    RF_TX_HP  = 3'd5
  } rf_mode_t;

  // I in the upper half, Q in the lower half
  typedef logic [`RADIO_SAMPLE_W-1:0] sample_t;

  // Bit 1 is the 0 deg bit and bit 0 the 180 deg bit
  typedef logic [1:0] ddr_pair_t;

endpackage

// ==== common/radio_params.svh ====
`ifndef RADIO_PARAMS_SVH
`define RADIO_PARAMS_SVH

// ========================================
// Bus widths
// ========================================
`define RADIO_BYTE_W          8       // SPI and SMI byte
`define RADIO_IOC_W           5       // Register number within a module
`define RADIO_SAMPLE_W        32      // One I/Q word

// ========================================
// LVDS framing
// ========================================
`define RADIO_PAIRS_PER_WORD  16      // DDR pairs in one sample word
`define RADIO_SYNC_PAIR       2'b10   // First pair of every word

// Sample buffer
`define RADIO_FIFO_DEPTH      8       // Words, keep a power of two

// ========================================
// Fixed register values
// ========================================
`define RADIO_VERSION         8'h02
`define RADIO_RESERVED_READ   8'hA5   // Returned for module select 3

`endif
